//--- hw/glb_defines.svh
// bank geometry macros for the global buffer, included by the package and the bank RTL
`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

// one bank word, as stored in the sram
`define GLB_DATA_WIDTH 64

// byte address of one bank, 4 KiB
`define GLB_ADDR_WIDTH 12

// byte-in-word bits below the row index
`define GLB_BYTE_OFFSET 3

// config port moves half a word
`define GLB_CFG_DATA_WIDTH 32

// one strobe bit per byte lane
`define GLB_STRB_WIDTH 8

`endif

//--- hw/glb_pkg.sv
// shared widths and channel structs of the global buffer bank, imported by every bank module
`default_nettype none

`include "glb_defines.svh"

package glb_pkg;

    // plain vectors with a meaning of their own
    typedef logic [`GLB_DATA_WIDTH-1:0] glb_data_t;
    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;
    // row index, byte offset stripped
    typedef logic [`GLB_ADDR_WIDTH-`GLB_BYTE_OFFSET-1:0] glb_word_addr_t;
    typedef logic [`GLB_STRB_WIDTH-1:0] glb_strb_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] glb_cfg_data_t;

    // data port request, strb only matters for writes
    typedef struct packed {
        logic      wr;
        glb_addr_t addr;
        glb_data_t data;
        glb_strb_t strb;
    } glb_req_t;

    // data port response, room for more fields later
    typedef struct packed {
        glb_data_t data;
    } glb_rsp_t;

    // config access, sampled every cycle
    typedef struct packed {
        logic          wr_en;
        logic          rd_en;
        glb_addr_t     addr;
        glb_cfg_data_t wr_data;
    } glb_cfg_req_t;

    // config read result, valid for one cycle
    typedef struct packed {
        glb_cfg_data_t rd_data;
        logic          rd_data_valid;
    } glb_cfg_rsp_t;

endpackage

`default_nettype wire

//--- hw/glb_sram_model.sv
// behavioral single-port sram of one bank, active-low enables and bit mask, registered read
`default_nettype none
`timescale 1ns/1ps

`include "glb_defines.svh"

module glb_sram_model (
    input  wire logic                   clk,
    input  wire logic                   cen,
    input  wire logic                   wen,
    input  wire glb_pkg::glb_word_addr_t a,
    input  wire glb_pkg::glb_data_t      d,
    input  wire glb_pkg::glb_data_t      bit_wen,
    output glb_pkg::glb_data_t           q
);

    import glb_pkg::*;

    // 512 rows, one per word index
    localparam int DEPTH = 1 << (`GLB_ADDR_WIDTH - `GLB_BYTE_OFFSET);

    // storage array, contents undefined until written
    glb_data_t mem [DEPTH];

    // write keeps bits whose mask bit is high
    always_ff @(posedge clk) begin
        if (!cen && !wen) begin
            mem[a] <= (mem[a] & bit_wen) | (d & ~bit_wen);
        end
    end

    // read lands on q one edge later
    // q holds on idle and write cycles
    always_ff @(posedge clk) begin
        if (!cen && wen) begin
            q <= mem[a];
        end
    end

endmodule

`default_nettype wire

//--- hw/glb_bank_memory.sv
// bank memory: arbitrates config and data accesses onto the sram and forms both read outputs
`default_nettype none
`timescale 1ns/1ps

`include "glb_defines.svh"

module glb_bank_memory (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 mem_ren,
    input  wire logic                 mem_wen,
    input  wire glb_pkg::glb_addr_t   mem_addr,
    input  wire glb_pkg::glb_data_t   mem_wdata,
    input  wire glb_pkg::glb_data_t   mem_bit_sel,
    output glb_pkg::glb_data_t        mem_rdata,
    output logic                      cfg_busy,
    input  wire glb_pkg::glb_cfg_req_t cfg_req,
    output glb_pkg::glb_cfg_rsp_t     cfg_rsp
);

    import glb_pkg::*;

    // active-high sram controls, inverted at the macro
    logic           sram_en;
    logic           sram_we;
    glb_word_addr_t sram_addr;
    glb_data_t      sram_wdata;
    glb_data_t      sram_bit_sel;
    glb_data_t      sram_q;

    // data-path read tracking
    logic      data_ren_d1;
    glb_data_t rdata_d1;

    // config read tracking
    logic cfg_ren_d1;
    logic cfg_half_d1;

    glb_sram_model i_glb_sram_model (
        .clk     (clk),
        .cen     (~sram_en),
        .wen     (~sram_we),
        .a       (sram_addr),
        .d       (sram_wdata),
        .bit_wen (~sram_bit_sel),
        .q       (sram_q)
    );

    // config port owns the sram whenever it asks
    assign cfg_busy = cfg_req.wr_en | cfg_req.rd_en;

    // priority: cfg write, cfg read, data access
    always_comb begin
        sram_en      = mem_ren | mem_wen;
        sram_we      = mem_wen;
        sram_addr    = mem_addr[`GLB_ADDR_WIDTH-1:`GLB_BYTE_OFFSET];
        sram_wdata   = mem_wdata;
        sram_bit_sel = mem_bit_sel;
        if (cfg_req.wr_en) begin
            sram_en    = 1'b1;
            sram_we    = 1'b1;
            sram_addr  = cfg_req.addr[`GLB_ADDR_WIDTH-1:`GLB_BYTE_OFFSET];
            // same value on both halves, mask picks one
            sram_wdata = {(`GLB_DATA_WIDTH/`GLB_CFG_DATA_WIDTH){cfg_req.wr_data}};
            if (cfg_req.addr[`GLB_BYTE_OFFSET-1]) begin
                sram_bit_sel = {{`GLB_CFG_DATA_WIDTH{1'b1}}, {`GLB_CFG_DATA_WIDTH{1'b0}}};
            end else begin
                sram_bit_sel = {{`GLB_CFG_DATA_WIDTH{1'b0}}, {`GLB_CFG_DATA_WIDTH{1'b1}}};
            end
        end else if (cfg_req.rd_en) begin
            sram_en      = 1'b1;
            sram_we      = 1'b0;
            sram_addr    = cfg_req.addr[`GLB_ADDR_WIDTH-1:`GLB_BYTE_OFFSET];
            sram_wdata   = '0;
            sram_bit_sel = '0;
        end
    end

    // controller only reads when cfg_busy is low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_ren_d1 <= 1'b0;
            rdata_d1    <= '0;
            cfg_ren_d1  <= 1'b0;
            cfg_half_d1 <= 1'b0;
        end else begin
            data_ren_d1 <= mem_ren;
            rdata_d1    <= mem_rdata;
            // a write in the same cycle wins, so no read result
            cfg_ren_d1  <= cfg_req.rd_en & ~cfg_req.wr_en;
            cfg_half_d1 <= cfg_req.addr[`GLB_BYTE_OFFSET-1];
        end
    end

    // fresh sram word right after a data read, else the held one
    assign mem_rdata = data_ren_d1 ? sram_q : rdata_d1;

    // half select for the config read result
    always_comb begin
        cfg_rsp.rd_data_valid = cfg_ren_d1;
        cfg_rsp.rd_data       = '0;
        if (cfg_ren_d1) begin
            cfg_rsp.rd_data = sram_q[cfg_half_d1*`GLB_CFG_DATA_WIDTH +: `GLB_CFG_DATA_WIDTH];
        end
    end

endmodule

`default_nettype wire

//--- hw/glb_bank_ctrl.sv
// data port controller of one bank: request handshake, strobe expansion, held response register
`default_nettype none
`timescale 1ns/1ps

`include "glb_defines.svh"

module glb_bank_ctrl (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire glb_pkg::glb_req_t  req,
    input  wire logic               req_valid,
    output logic                    req_ready,
    output glb_pkg::glb_rsp_t       rsp,
    output logic                    rsp_valid,
    input  wire logic               rsp_ready,
    input  wire logic               cfg_busy,
    output logic                    mem_ren,
    output logic                    mem_wen,
    output glb_pkg::glb_addr_t      mem_addr,
    output glb_pkg::glb_data_t      mem_wdata,
    output glb_pkg::glb_data_t      mem_bit_sel,
    input  wire glb_pkg::glb_data_t mem_rdata
);

    // transfer on this edge
    logic req_fire;
    // read issued last edge, data on mem_rdata now
    logic rd_pending;

    // stall for cfg, an sram read in flight, or a held response
    assign req_ready = ~cfg_busy & ~rd_pending & ~(rsp_valid & ~rsp_ready);
    assign req_fire  = req_valid & req_ready;

    // one sram access per transfer
    assign mem_wen   = req_fire & req.wr;
    assign mem_ren   = req_fire & ~req.wr;
    assign mem_addr  = req.addr;
    assign mem_wdata = req.data;

    // each strobe bit covers one byte lane
    always_comb begin
        for (int i = 0; i < `GLB_STRB_WIDTH; i++) begin
            mem_bit_sel[i*8 +: 8] = {8{req.strb[i]}};
        end
    end

    // pending flag and response valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pending <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            rd_pending <= mem_ren;
            if (rd_pending) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // response payload, only loaded when a read returns
    // a read never issues while a response is held, so no overwrite
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            rsp.data <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/glb_bank.sv
// top level of one global buffer bank, joins the data port controller and the bank memory
`default_nettype none
`timescale 1ns/1ps

module glb_bank (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire glb_pkg::glb_req_t     req,
    input  wire logic                  req_valid,
    output logic                       req_ready,
    output glb_pkg::glb_rsp_t          rsp,
    output logic                       rsp_valid,
    input  wire logic                  rsp_ready,
    input  wire glb_pkg::glb_cfg_req_t cfg_req,
    output glb_pkg::glb_cfg_rsp_t      cfg_rsp
);

    import glb_pkg::*;

    // data access from controller to memory
    logic      mem_ren;
    logic      mem_wen;
    glb_addr_t mem_addr;
    glb_data_t mem_wdata;
    glb_data_t mem_bit_sel;
    // held read word and config ownership back to controller
    glb_data_t mem_rdata;
    logic      cfg_busy;

    glb_bank_ctrl i_glb_bank_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .cfg_busy    (cfg_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_bit_sel (mem_bit_sel),
        .mem_rdata   (mem_rdata)
    );

    glb_bank_memory i_glb_bank_memory (
        .clk         (clk),
        .reset       (reset),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_bit_sel (mem_bit_sel),
        .mem_rdata   (mem_rdata),
        .cfg_busy    (cfg_busy),
        .cfg_req     (cfg_req),
        .cfg_rsp     (cfg_rsp)
    );

endmodule

`default_nettype wire

//--- tests/glb_bank_assert.sv
// concurrent handshake and config timing checks, bound into the bank top from this file
`default_nettype none
`timescale 1ns/1ps

module glb_bank_assert (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire glb_pkg::glb_req_t     req,
    input wire logic                  req_valid,
    input wire logic                  req_ready,
    input wire glb_pkg::glb_rsp_t     rsp,
    input wire logic                  rsp_valid,
    input wire logic                  rsp_ready,
    input wire logic                  cfg_busy,
    input wire glb_pkg::glb_cfg_req_t cfg_req,
    input wire glb_pkg::glb_cfg_rsp_t cfg_rsp
);

    // failed assertions so far, picked up by the testbench
    int fail_count = 0;

    // waiting request keeps valid and payload
    req_held: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
        $error("request changed while waiting for ready");
        fail_count++;
    end

    // held response keeps valid and payload
    rsp_held: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $error("response changed under back-pressure");
        fail_count++;
    end

    // rd_data_valid exactly one cycle after a config read, write wins
    cfg_rd_timing: assert property (@(posedge clk) disable iff (reset)
        cfg_rsp.rd_data_valid == $past(cfg_req.rd_en && !cfg_req.wr_en))
    else begin
        $error("rd_data_valid out of step with config read");
        fail_count++;
    end

    // config port owns the sram, data port must stall
    cfg_blocks_req: assert property (@(posedge clk) disable iff (reset)
        cfg_busy |-> !req_ready)
    else begin
        $error("req_ready high while config port busy");
        fail_count++;
    end

endmodule

bind glb_bank glb_bank_assert i_glb_bank_assert (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .cfg_busy  (cfg_busy),
    .cfg_req   (cfg_req),
    .cfg_rsp   (cfg_rsp)
);

`default_nettype wire

//--- tests/glb_bank_tb.sv
// directed testbench of one global buffer bank, compiled from src.f with the assertions bound in
`default_nettype none
`timescale 1ns/1ps

`include "glb_defines.svh"

module glb_bank_tb;

    import glb_pkg::*;

    localparam int clk_period = 40;
    localparam int num_words  = 1 << (`GLB_ADDR_WIDTH - `GLB_BYTE_OFFSET);
    // fill, directed and random requests, 200 cycles each
    localparam int num_requests = num_words + 40 + 200;
    localparam int timeout_ns   = (num_requests * 200 + 500) * clk_period;
    // longest single handshake wait, in cycles
    localparam int wait_limit = 50;

    logic         clk;
    logic         reset;
    glb_req_t     req;
    logic         req_valid;
    logic         req_ready;
    glb_rsp_t     rsp;
    logic         rsp_valid;
    logic         rsp_ready;
    glb_cfg_req_t cfg_req;
    glb_cfg_rsp_t cfg_rsp;

    // expected contents of every sram row
    glb_data_t ref_mem [num_words];
    int        seed = 32'hae8;
    int        data_errors = 0;
    int        proto_errors = 0;
    int        assert_errors = 0;

    glb_bank i_glb_bank (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .cfg_req   (cfg_req),
        .cfg_rsp   (cfg_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // stuck run guard
    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, a handshake never finished", timeout_ns);
        $display("Checks failed");
        $finish;
    end

    task automatic check_data(input glb_data_t got, input glb_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %h expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_cfg(input glb_cfg_data_t got, input glb_cfg_data_t exp,
                             input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %h expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic protocol_fail(input string what);
        $display("protocol failure at %0t ns: %s", $time, what);
        proto_errors++;
    endtask

    // byte-lane merge, set strobe takes the new byte
    function automatic void ref_write(input glb_addr_t addr, input glb_data_t data,
                                      input glb_strb_t s);
        glb_data_t mask;
        mask = {{8{s[7]}}, {8{s[6]}}, {8{s[5]}}, {8{s[4]}},
                {8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        ref_mem[addr[11:3]] = (ref_mem[addr[11:3]] & ~mask) | (data & mask);
    endfunction

    // address bit 2 picks the half
    function automatic glb_cfg_data_t ref_half(input glb_addr_t addr);
        return addr[2] ? ref_mem[addr[11:3]][63:32] : ref_mem[addr[11:3]][31:0];
    endfunction

    task automatic send_req(input glb_req_t r);
        int waited;
        waited = 0;
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        #1;
        while (!req_ready && waited < wait_limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!req_ready) begin
            protocol_fail("request was never accepted");
        end else if (r.wr) begin
            ref_write(r.addr, r.data, r.strb);
        end
        // transfer edge lies behind this negedge
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic recv_rsp(input logic random_ready, output glb_data_t data, output logic ok);
        int waited;
        int r;
        waited = 0;
        ok     = 1'b0;
        data   = '0;
        while (!ok && waited < wait_limit) begin
            @(negedge clk);
            r = $random(seed);
            rsp_ready = random_ready ? r[0] : 1'b1;
            #1;
            if (rsp_valid && rsp_ready) begin
                data = rsp.data;
                ok   = 1'b1;
            end
            waited++;
        end
        if (!ok) begin
            protocol_fail("read gave no rsp_valid");
        end
    endtask

    task automatic write_word(input glb_addr_t addr, input glb_data_t data, input glb_strb_t s);
        glb_req_t r;
        r = '{wr: 1'b1, addr: addr, data: data, strb: s};
        send_req(r);
    endtask

    task automatic read_check(input glb_addr_t addr, input logic random_ready, input string what);
        glb_req_t  r;
        glb_data_t got;
        logic      ok;
        r = '{wr: 1'b0, addr: addr, data: 64'h0, strb: 8'h0};
        send_req(r);
        recv_rsp(random_ready, got, ok);
        if (ok) begin
            check_data(got, ref_mem[addr[11:3]], what);
        end
    endtask

    task automatic cfg_write(input glb_addr_t addr, input glb_cfg_data_t d);
        @(negedge clk);
        cfg_req = '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wr_data: d};
        if (addr[2]) ref_mem[addr[11:3]][63:32] = d;
        else ref_mem[addr[11:3]][31:0] = d;
        @(negedge clk);
        cfg_req = '0;
    endtask

    task automatic cfg_read_check(input glb_addr_t addr, input string what);
        @(negedge clk);
        cfg_req = '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wr_data: 32'h0};
        @(negedge clk);
        cfg_req = '0;
        #1;
        if (!cfg_rsp.rd_data_valid) protocol_fail("config read gave no rd_data_valid");
        else check_cfg(cfg_rsp.rd_data, ref_half(addr), what);
        @(negedge clk);
        #1;
        if (cfg_rsp.rd_data_valid) protocol_fail("rd_data_valid high for more than one cycle");
    endtask

    // whole-address pattern so every row starts known
    task automatic fill_memory();
        glb_word_addr_t w;
        for (int i = 0; i < num_words; i++) begin
            w = glb_word_addr_t'(i);
            write_word({w, 3'b000}, {w, 23'h5a5a5, ~w, 23'h0c3c3}, 8'hff);
        end
    endtask

    task automatic test_full_words();
        glb_addr_t addrs [4];
        glb_data_t d;
        int        r;
        addrs = '{12'h008, 12'h1f0, 12'h7f8, 12'hff8};
        foreach (addrs[i]) begin
            r = $random(seed);
            d[31:0] = r;
            r = $random(seed);
            d[63:32] = r;
            write_word(addrs[i], d, 8'hff);
        end
        foreach (addrs[i]) read_check(addrs[i], 1'b0, "full word read");
    endtask

    task automatic test_partial_write();
        write_word(12'h140, 64'h0011_2233_4455_6677, 8'hff);
        // lanes 7, 5, 2 and 0 take the new bytes
        write_word(12'h140, 64'hffee_ddcc_bbaa_9988, 8'b1010_0101);
        read_check(12'h140, 1'b0, "strobed write merge");
    endtask

    task automatic test_cfg_port();
        cfg_write(12'h200, 32'hdead_beef);
        cfg_write(12'h204, 32'h0bad_f00d);
        read_check(12'h200, 1'b0, "config halves read on data port");
        write_word(12'h208, 64'h8877_6655_4433_2211, 8'hff);
        cfg_read_check(12'h208, "config read low half");
        cfg_read_check(12'h20c, "config read high half");
    endtask

    task automatic expect_stall(input string what);
        #1;
        if (req_ready) protocol_fail({"req_ready high during ", what});
    endtask

    task automatic test_cfg_stall();
        glb_data_t got;
        logic      ok;
        @(negedge clk);
        req       = '{wr: 1'b0, addr: 12'h300, data: 64'h0, strb: 8'h0};
        req_valid = 1'b1;
        cfg_req   = '{wr_en: 1'b1, rd_en: 1'b0, addr: 12'h300, wr_data: 32'h1357_9bdf};
        ref_mem[glb_word_addr_t'(12'h300 >> 3)][31:0] = 32'h1357_9bdf;
        expect_stall("config write low half");
        @(negedge clk);
        cfg_req = '{wr_en: 1'b1, rd_en: 1'b0, addr: 12'h304, wr_data: 32'h2468_ace0};
        ref_mem[glb_word_addr_t'(12'h304 >> 3)][63:32] = 32'h2468_ace0;
        expect_stall("config write high half");
        @(negedge clk);
        cfg_req = '{wr_en: 1'b0, rd_en: 1'b1, addr: 12'h300, wr_data: 32'h0};
        expect_stall("config read");
        @(negedge clk);
        cfg_req = '0;
        #1;
        if (!cfg_rsp.rd_data_valid) protocol_fail("config read gave no rd_data_valid");
        else check_cfg(cfg_rsp.rd_data, ref_half(12'h300), "config read during stall");
        if (!req_ready) protocol_fail("request still stalled after config traffic");
        // held request transfers on this edge
        @(negedge clk);
        req_valid = 1'b0;
        recv_rsp(1'b0, got, ok);
        if (ok) begin
            check_data(got, ref_mem[glb_word_addr_t'(12'h300 >> 3)],
                       "read held through config traffic");
        end
    endtask

    task automatic test_backpressure();
        glb_req_t  r;
        glb_data_t held;
        glb_data_t got;
        logic      ok;
        int        waited;
        r = '{wr: 1'b0, addr: 12'h0a8, data: 64'h0, strb: 8'h0};
        @(negedge clk);
        rsp_ready = 1'b0;
        send_req(r);
        waited = 0;
        #1;
        while (!rsp_valid && waited < wait_limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!rsp_valid) protocol_fail("read under back-pressure gave no rsp_valid");
        held = rsp.data;
        repeat (5) begin
            @(negedge clk);
            #1;
            if (!rsp_valid || rsp.data !== held || req_ready) begin
                protocol_fail("response not held or req_ready high under back-pressure");
            end
        end
        recv_rsp(1'b0, got, ok);
        if (ok) check_data(got, ref_mem[r.addr[11:3]], "read released after back-pressure");
    endtask

    task automatic test_random();
        glb_req_t rq;
        int       r;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            rq.wr   = r[0];
            rq.strb = r[15:8];
            rq.addr = r[27:16];
            r = $random(seed);
            rq.data[31:0] = r;
            r = $random(seed);
            rq.data[63:32] = r;
            if (rq.wr) send_req(rq);
            else read_check(rq.addr, 1'b1, "random read");
        end
    endtask

    initial begin
        reset     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        cfg_req   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        if (rsp_valid || cfg_rsp.rd_data_valid) protocol_fail("valid output high after reset");
        fill_memory();
        test_full_words();
        test_partial_write();
        test_cfg_port();
        test_cfg_stall();
        test_backpressure();
        test_random();
        assert_errors = i_glb_bank.i_glb_bank_assert.fail_count;
        $display("closing: %0d data errors, %0d protocol errors, %0d assertion failures",
                 data_errors, proto_errors, assert_errors);
        if (data_errors + proto_errors + assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/glb_pkg.sv
hw/glb_sram_model.sv
hw/glb_bank_memory.sv
hw/glb_bank_ctrl.sv
hw/glb_bank.sv
tests/glb_bank_assert.sv
tests/glb_bank_tb.sv

//--- run.sh
#!/bin/sh
# build the bank testbench with verilator and run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module glb_bank_tb -o sim_glb_bank
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_glb_bank)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
